/* logic/sensors_pkg.sv */
//############################################################
// sensor subsystem package
// address map, data widths, status packet length and the
// structs shared by the command, pixel and buffer paths
//############################################################
package sensors_pkg;

    localparam int NUM_SENSORS         = 4;      // channels
    localparam int SENSOR_GROUP_ADDR   = 'h400;  // channel 0 register base
    localparam int SENSOR_BASE_INC     = 'h40;   // per-channel address step
    localparam int SENSOR_MODE_RADDR   = 0;      // mode register offset
    localparam int SENSOR_STATUS_RADDR = 1;      // status request offset

    localparam int STATUS_REG_BASE     = 'h30;   // packet address byte, channel 0
    localparam int STATUS_REG_INC      = 2;      // address byte step
    localparam int STATUS_PKT_BYTES    = 4;      // addr, mode/seq, line lo, line hi

    localparam int SENSOR_DATA_WIDTH   = 12;     // raw pixel bits
    localparam int BUF_WORD_WIDTH      = 64;     // line buffer word
    localparam int BUF_PAGE_BITS       = 6;      // 64 words per page
    localparam int BUF_NPAGE_BITS      = 2;      // 4 pages
    localparam int LINE_CNT_WIDTH      = 16;

    // one register write off the command bus
    typedef struct packed {
        logic [15:0] addr; // register address
        logic [31:0] data; // register data
    } cmd_wr_t;

    // pixel strobe from a sensor channel
    typedef struct packed {
        logic [SENSOR_DATA_WIDTH-1:0] data;
        logic                         valid; // pixel present
        logic                         last;  // last pixel in line
    } pix_in_t;

    typedef struct packed {
        logic enable; // accept pixels
        logic bpp16;  // 1 - 16 bit pixels, 0 - 8 bit
    } chan_mode_t;

    // packed word towards the line buffer
    typedef struct packed {
        logic [BUF_WORD_WIDTH-1:0] data;
        logic                      valid; // write strobe
        logic                      eol;   // word closes the page
    } buf_wr_t;

endpackage

/* logic/cmd_deser.sv */
//############################################################
// command deserializer
// collects address low/high and four data bytes from the
// byte-serial command port into one register write pulse
//############################################################
`timescale 1ns/100ps

module cmd_deser import sensors_pkg::*; (
    input  logic       mclk,
    input  logic       rst_n,
    input  logic [7:0] cmd_ad_in,  // AL-AH-D0-D1-D2-D3
    input  logic       cmd_stb_in, // with the first byte
    output cmd_wr_t    cmd_wr,
    output logic       wr_stb      // one cycle, cmd_wr valid
);

    logic [7:0]  ad_r;  // registered byte bus
    logic        stb_r;
    logic [47:0] sr;    // byte assembly, lsb first
    logic [2:0]  cnt;   // bytes taken
    logic        busy;
    logic        done;  // last byte shifted in

    always_ff @(posedge mclk) begin
        ad_r <= cmd_ad_in;
        if (stb_r || busy) begin
            sr <= {ad_r, sr[47:8]}; // new byte enters at the top
        end
        if (done) begin
            cmd_wr.addr <= sr[15:0];
            cmd_wr.data <= sr[47:16];
        end
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            stb_r  <= 1'b0;
            busy   <= 1'b0;
            cnt    <= 3'd0;
            done   <= 1'b0;
            wr_stb <= 1'b0;
        end else begin
            stb_r  <= cmd_stb_in;
            wr_stb <= done;
            done   <= 1'b0;
            if (stb_r) begin // new strobe restarts collection
                busy <= 1'b1;
                cnt  <= 3'd1;
            end else if (busy) begin
                cnt <= cnt + 3'd1;
                if (cnt == 3'd5) begin // sixth byte going in
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/sensor_ctrl.sv */
//############################################################
// sensor channel control
// decodes the channel address window, holds the mode and the
// status request, sends the four-byte status packet
//############################################################
`timescale 1ns/100ps

module sensor_ctrl import sensors_pkg::*; #(
    parameter int CHAN = 0 // channel number
) (
    input  logic                      mclk,
    input  logic                      rst_n,
    input  cmd_wr_t                   cmd_wr,
    input  logic                      wr_stb,
    input  logic [LINE_CNT_WIDTH-1:0] line_cnt,
    output chan_mode_t                mode,
    output logic [7:0]                status_ad,
    output logic                      status_rq,
    input  logic                      status_start
);

    localparam logic [15:0] BASE   = 16'(SENSOR_GROUP_ADDR + CHAN * SENSOR_BASE_INC);
    localparam logic [7:0]  PKT_AD = 8'(STATUS_REG_BASE + CHAN * STATUS_REG_INC);

    logic                      mode_we;   // mode register hit
    logic                      status_we; // status request hit
    logic [5:0]                seq;       // sequence from last request
    logic [LINE_CNT_WIDTH-1:0] lc_r;      // line count at start
    logic [1:0]                snd_cnt;   // packet byte, 0 - address

    assign mode_we   = wr_stb && (cmd_wr.addr == BASE + 16'(SENSOR_MODE_RADDR));
    assign status_we = wr_stb && (cmd_wr.addr == BASE + 16'(SENSOR_STATUS_RADDR));

    always_comb begin
        case (snd_cnt)
            2'd1:    status_ad = {mode.bpp16, mode.enable, seq};
            2'd2:    status_ad = lc_r[7:0];  // line count low
            2'd3:    status_ad = lc_r[15:8];
            default: status_ad = PKT_AD;     // byte 0 while pending
        endcase
    end

    always_ff @(posedge mclk) begin
        if (status_we) seq <= cmd_wr.data[5:0]; // newer request overwrites
        if (status_start) lc_r <= line_cnt;     // sampled with byte 0
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            mode      <= '0;
            status_rq <= 1'b0;
            snd_cnt   <= 2'd0;
        end else begin
            if (mode_we) begin
                mode.enable <= cmd_wr.data[0];
                mode.bpp16  <= cmd_wr.data[8];
            end
            if (status_we) status_rq <= 1'b1;
            else if (status_start) status_rq <= 1'b0; // drop after byte 0
            if (status_start) snd_cnt <= 2'd1;
            else if (snd_cnt != 2'd0) begin
                snd_cnt <= (snd_cnt == 2'(STATUS_PKT_BYTES - 1)) ? 2'd0 : snd_cnt + 2'd1;
            end
        end
    end

endmodule

/* logic/pixel_packer.sv */
//############################################################
// pixel packer
// shifts 8 or 16 bit pixels into 64-bit buffer words, flushes
// a padded word at line end and counts finished lines
//############################################################
`timescale 1ns/100ps

module pixel_packer import sensors_pkg::*; (
    input  logic                      mclk,
    input  logic                      rst_n,
    input  chan_mode_t                mode,
    input  pix_in_t                   pix_in,
    output buf_wr_t                   buf_wr,
    output logic [LINE_CNT_WIDTH-1:0] line_cnt
);

    logic [BUF_WORD_WIDTH-1:0] acc;      // shift accumulator
    logic [BUF_WORD_WIDTH-1:0] acc_next; // with current pixel
    logic [3:0]                cnt;      // pixels in acc
    logic [3:0]                n_next;
    logic [7:0]                fill;     // bits filled incl. current
    logic [7:0]                shamt;    // align first pixel to bit 0
    logic                      take;
    logic                      full;

    assign take   = pix_in.valid && mode.enable;
    assign n_next = cnt + 4'd1;
    assign full   = mode.bpp16 ? (n_next == 4'd4) : (n_next == 4'd8);
    assign fill   = mode.bpp16 ? {n_next, 4'b0} : {1'b0, n_next, 3'b0};
    assign shamt  = 8'(BUF_WORD_WIDTH) - fill; // zero when the word is full

    always_comb begin
        if (mode.bpp16) begin // zero-extended 16 bit pixel
            acc_next = {{(16 - SENSOR_DATA_WIDTH){1'b0}}, pix_in.data, acc[63:16]};
        end else begin        // msbs only
            acc_next = {pix_in.data[SENSOR_DATA_WIDTH-1 -: 8], acc[63:8]};
        end
    end

    always_ff @(posedge mclk) begin
        if (take) acc <= acc_next;
        if (take && (full || pix_in.last)) begin
            buf_wr.data <= acc_next >> shamt; // padding shifts in from the top
        end
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            cnt          <= 4'd0;
            buf_wr.valid <= 1'b0;
            buf_wr.eol   <= 1'b0;
            line_cnt     <= '0;
        end else begin
            buf_wr.valid <= 1'b0;
            if (take) begin
                cnt <= (full || pix_in.last) ? 4'd0 : n_next;
                buf_wr.valid <= full || pix_in.last;
                buf_wr.eol   <= pix_in.last;
                if (pix_in.last) line_cnt <= line_cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/sensor_membuf.sv */
//############################################################
// sensor line buffer
// four 64-word pages of 64-bit words, one line per page,
// read by the memory client with page set/next and buf_rd
//############################################################
`timescale 1ns/100ps

module sensor_membuf import sensors_pkg::*; (
    input  logic                      mclk,
    input  logic                      rst_n,
    input  buf_wr_t                   buf_wr,
    input  logic                      rpage_set,  // page 0, word 0
    input  logic                      rpage_next, // next page, word 0
    input  logic                      buf_rd,     // read word, advance
    output logic [BUF_WORD_WIDTH-1:0] buf_dout
);

    localparam int DEPTH = 2 ** (BUF_PAGE_BITS + BUF_NPAGE_BITS);

    logic [BUF_WORD_WIDTH-1:0] ram [DEPTH];
    logic [BUF_NPAGE_BITS-1:0] wpage;
    logic [BUF_PAGE_BITS-1:0]  waddr;
    logic [BUF_NPAGE_BITS-1:0] rpage;
    logic [BUF_PAGE_BITS-1:0]  raddr;
    logic [BUF_WORD_WIDTH-1:0] ram_q; // registered ram read
    logic                      rd_d;  // ram_q valid

    always_ff @(posedge mclk) begin
        if (buf_wr.valid) ram[{wpage, waddr}] <= buf_wr.data;
        if (buf_rd) ram_q <= ram[{rpage, raddr}];
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            wpage <= '0;
            waddr <= '0;
        end else if (buf_wr.valid) begin
            if (buf_wr.eol) begin // line done, next page mod 4
                wpage <= wpage + 1'b1;
                waddr <= '0;
            end else begin
                waddr <= waddr + 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            rpage    <= '0;
            raddr    <= '0;
            rd_d     <= 1'b0;
            buf_dout <= '0;
        end else begin
            rd_d <= buf_rd;
            if (rd_d) buf_dout <= ram_q; // second stage
            if (rpage_set) begin
                rpage <= '0;
                raddr <= '0;
            end else if (rpage_next) begin
                rpage <= rpage + 1'b1;
                raddr <= '0;
            end else if (buf_rd) begin
                raddr <= raddr + 1'b1;
            end
        end
    end

endmodule

/* logic/status_router4.sv */
//############################################################
// status router
// round-robin merge of four channel status streams onto one
// byte bus, selection held for a whole packet
//############################################################
`timescale 1ns/100ps

module status_router4 import sensors_pkg::*; (
    input  logic                   mclk,
    input  logic                   rst_n,
    input  logic [7:0]             db_in [NUM_SENSORS],
    input  logic [NUM_SENSORS-1:0] rq_in,
    output logic [NUM_SENSORS-1:0] start_in,
    output logic [7:0]             db_out,
    output logic                   rq_out,
    input  logic                   start_out
);

    localparam int SEL_W = $clog2(NUM_SENSORS);

    logic [SEL_W-1:0] sel_r; // channel served last / being served
    logic [SEL_W-1:0] pick;  // next requester after sel_r
    logic [SEL_W-1:0] cur;
    logic [1:0]       cnt;   // packet byte being forwarded
    logic             busy;  // bytes 1..3 in flight

    always_comb begin
        logic [SEL_W-1:0] idx;
        pick = sel_r;
        for (int i = NUM_SENSORS; i >= 1; i--) begin // nearest one wins
            idx = sel_r + SEL_W'(i);
            if (rq_in[idx]) pick = idx;
        end
    end

    assign cur      = busy ? sel_r : pick;
    assign db_out   = db_in[cur];
    assign rq_out   = !busy && rq_in[cur]; // hide rq mid-packet
    assign start_in = (!busy && start_out) ? (NUM_SENSORS'(1) << cur) : '0;

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            sel_r <= '1; // channel 0 goes first
            cnt   <= 2'd0;
            busy  <= 1'b0;
        end else if (!busy) begin
            if (start_out) begin
                sel_r <= pick;
                busy  <= 1'b1;
                cnt   <= 2'd1;
            end
        end else begin
            cnt <= cnt + 2'd1;
            if (cnt == 2'(STATUS_PKT_BYTES - 1)) busy <= 1'b0; // last byte out
        end
    end

endmodule

/* logic/sensors_top.sv */
//############################################################
// four-channel sensor subsystem, command-port side
// command deserializer, per-channel control, packer and line
// buffer, and the status router, all on mclk
//############################################################
`timescale 1ns/100ps

module sensors_top import sensors_pkg::*; (
    input  logic                      mclk,
    input  logic                      rst_n,
    input  logic [7:0]                cmd_ad_in,
    input  logic                      cmd_stb_in,
    output logic [7:0]                status_ad,
    output logic                      status_rq,
    input  logic                      status_start,
    input  pix_in_t                   pix_in [NUM_SENSORS],
    input  logic [NUM_SENSORS-1:0]    rpage_set,
    input  logic [NUM_SENSORS-1:0]    rpage_next,
    input  logic [NUM_SENSORS-1:0]    buf_rd,
    output logic [BUF_WORD_WIDTH-1:0] buf_dout [NUM_SENSORS]
);

    cmd_wr_t                   cmd_wr;
    logic                      wr_stb;
    chan_mode_t                mode [NUM_SENSORS];
    logic [LINE_CNT_WIDTH-1:0] line_cnt [NUM_SENSORS];
    buf_wr_t                   buf_wr [NUM_SENSORS];
    logic [7:0]                st_ad [NUM_SENSORS];  // channel status bytes
    logic [NUM_SENSORS-1:0]    st_rq;
    logic [NUM_SENSORS-1:0]    st_start;

    cmd_deser cmd_deser_i (
        .mclk       (mclk),
        .rst_n      (rst_n),
        .cmd_ad_in  (cmd_ad_in),
        .cmd_stb_in (cmd_stb_in),
        .cmd_wr     (cmd_wr),
        .wr_stb     (wr_stb)
    );

    for (genvar i = 0; i < NUM_SENSORS; i++) begin : g_chan
        sensor_ctrl #(.CHAN(i)) sensor_ctrl_i (
            .mclk         (mclk),
            .rst_n        (rst_n),
            .cmd_wr       (cmd_wr),
            .wr_stb       (wr_stb),
            .line_cnt     (line_cnt[i]),
            .mode         (mode[i]),
            .status_ad    (st_ad[i]),
            .status_rq    (st_rq[i]),
            .status_start (st_start[i])
        );

        pixel_packer pixel_packer_i (
            .mclk     (mclk),
            .rst_n    (rst_n),
            .mode     (mode[i]),     // steered by its own ctrl
            .pix_in   (pix_in[i]),
            .buf_wr   (buf_wr[i]),
            .line_cnt (line_cnt[i])
        );

        sensor_membuf sensor_membuf_i (
            .mclk       (mclk),
            .rst_n      (rst_n),
            .buf_wr     (buf_wr[i]),
            .rpage_set  (rpage_set[i]),
            .rpage_next (rpage_next[i]),
            .buf_rd     (buf_rd[i]),
            .buf_dout   (buf_dout[i])
        );
    end

    status_router4 status_router4_i (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .db_in     (st_ad),
        .rq_in     (st_rq),
        .start_in  (st_start),
        .db_out    (status_ad),
        .rq_out    (status_rq),
        .start_out (status_start)
    );

endmodule

/* sim/tb_clkgen.sv */
//############################################################
// testbench clock and reset source
// free-running mclk, rst_n held low for the first cycles
//############################################################
`timescale 1ns/100ps

module tb_clkgen #(
    parameter real PERIOD     = 8.0, // ns
    parameter int  RST_CYCLES = 2
) (
    output logic mclk,
    output logic rst_n
);

    initial begin
        mclk = 1'b0;
        forever #(PERIOD / 2.0) mclk = ~mclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge mclk); // two sampling edges in reset
        @(negedge mclk);
        rst_n = 1'b1;
    end

endmodule

/* sim/sensors_tb.sv */
//############################################################
// sensor subsystem testbench
// drives commands and pixels on the falling edge, keeps a
// per-channel model of mode, line count and buffer pages,
// checks buffer readback and status packets
//############################################################
`timescale 1ns/100ps

module sensors_tb import sensors_pkg::*; ();

    localparam logic [15:0] SEED   = 16'd51392;
    localparam int LINES_PER_CHAN  = 2;            // 2+2 lines keep pages aligned
    localparam int SETTLE_CYC      = 4;            // write reaches the mode reg
    localparam int CMD_CYC         = 6 + SETTLE_CYC;
    localparam int LINE_CYC        = 64 + 2;
    localparam int READ_CYC        = 1 + 4 * (16 * 2 + 1);
    localparam int PKT_CYC         = 10 + 8 + 5;   // rq delay, random wait, bytes
    localparam int T2_CYC          = 4 * (CMD_CYC + LINES_PER_CHAN * LINE_CYC + READ_CYC);
    localparam int T4_CYC          = 3 * CMD_CYC + 2 * LINE_CYC + READ_CYC + PKT_CYC;
    localparam int T6_CYC          = CMD_CYC + 6 * LINE_CYC + READ_CYC;
    localparam int TIMEOUT_CYC     = 4 + 2 * T2_CYC + T4_CYC + 4 * PKT_CYC + T6_CYC + 500;

    logic                      mclk;
    logic                      rst_n;
    logic [7:0]                cmd_ad_in;
    logic                      cmd_stb_in;
    logic [7:0]                status_ad;
    logic                      status_rq;
    logic                      status_start;
    pix_in_t                   pix_in [NUM_SENSORS];
    logic [NUM_SENSORS-1:0]    rpage_set;
    logic [NUM_SENSORS-1:0]    rpage_next;
    logic [NUM_SENSORS-1:0]    buf_rd;
    logic [BUF_WORD_WIDTH-1:0] buf_dout [NUM_SENSORS];

    logic [15:0] lfsr_state;
    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    logic [63:0] exp_word [NUM_SENSORS][4][64]; // model pages
    int          exp_len  [NUM_SENSORS][4];     // words per page
    int          wpage_m  [NUM_SENSORS];
    int          lcnt_m   [NUM_SENSORS];
    logic        en_m     [NUM_SENSORS];
    logic        bpp_m    [NUM_SENSORS];
    logic [5:0]  seq_m    [NUM_SENSORS];

    tb_clkgen #(.PERIOD(8.0), .RST_CYCLES(2)) clkgen0 (.mclk(mclk), .rst_n(rst_n));

    sensors_top dut0 (
        .mclk         (mclk),
        .rst_n        (rst_n),
        .cmd_ad_in    (cmd_ad_in),
        .cmd_stb_in   (cmd_stb_in),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start),
        .pix_in       (pix_in),
        .rpage_set    (rpage_set),
        .rpage_next   (rpage_next),
        .buf_rd       (buf_rd),
        .buf_dout     (buf_dout)
    );

    // galois lfsr, x^16+x^14+x^13+x^11+1, one step per bit
    function automatic logic [31:0] next_rand(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %-18s ok", name);
        end else begin
            tests_failed++;
            $display("test %-18s FAILED, %0d errors", name, errors - err0);
        end
    endtask

    // six bytes, address low first
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [7:0] cmd_bytes [6];
        cmd_bytes = '{addr[7:0], addr[15:8], data[7:0], data[15:8], data[23:16], data[31:24]};
        for (int i = 0; i < 6; i++) begin
            cmd_stb_in = (i == 0);
            cmd_ad_in  = cmd_bytes[i];
            @(negedge mclk);
        end
        cmd_stb_in = 1'b0;
        cmd_ad_in  = 8'h00;
    endtask

    task automatic set_mode(input int ch, input logic en, input logic bpp16);
        write_reg(16'(SENSOR_GROUP_ADDR + ch * SENSOR_BASE_INC + SENSOR_MODE_RADDR),
                  {23'd0, bpp16, 7'd0, en});
        repeat (SETTLE_CYC) @(negedge mclk);
        en_m[ch]  = en;
        bpp_m[ch] = bpp16;
    endtask

    task automatic request_status(input int ch, input logic [5:0] seq);
        write_reg(16'(SENSOR_GROUP_ADDR + ch * SENSOR_BASE_INC + SENSOR_STATUS_RADDR),
                  {26'd0, seq});
        seq_m[ch] = seq;
    endtask

    // one line of random pixels, model packs in parallel
    task automatic feed_line(input int ch, input int len);
        logic [11:0] px;
        logic [63:0] word;
        logic [63:0] words [64];
        int          k;
        int          nw;
        word = '0;
        k    = 0;
        nw   = 0;
        for (int i = 0; i < len; i++) begin
            px = 12'(next_rand(12));
            pix_in[ch].data  = px;
            pix_in[ch].valid = 1'b1;
            pix_in[ch].last  = (i == len - 1);
            if (bpp_m[ch]) word = word | (64'(px) << (16 * k)); // zero-extended
            else           word = word | (64'(px[11:4]) << (8 * k));
            k++;
            if (k == (bpp_m[ch] ? 4 : 8) || i == len - 1) begin // full or flush
                words[nw] = word;
                nw++;
                word = '0;
                k    = 0;
            end
            @(negedge mclk);
        end
        pix_in[ch] = '0;
        if (en_m[ch]) begin // disabled lines leave no trace
            for (int w = 0; w < nw; w++) exp_word[ch][wpage_m[ch]][w] = words[w];
            exp_len[ch][wpage_m[ch]] = nw;
            wpage_m[ch] = (wpage_m[ch] + 1) % 4;
            lcnt_m[ch]++;
        end
        repeat (2) @(negedge mclk);
    endtask

    // all pages, set then next, one word per buf_rd
    task automatic read_back(input int ch);
        rpage_set[ch] = 1'b1;
        @(negedge mclk);
        rpage_set[ch] = 1'b0;
        for (int p = 0; p < 4; p++) begin
            for (int w = 0; w < exp_len[ch][p]; w++) begin
                buf_rd[ch] = 1'b1;
                @(negedge mclk);
                buf_rd[ch] = 1'b0;
                @(negedge mclk); // word is out 2 cycles after buf_rd
                check_value($sformatf("buf_dout[%0d] page %0d word %0d", ch, p, w),
                            exp_word[ch][p][w], buf_dout[ch]);
            end
            rpage_next[ch] = 1'b1;
            @(negedge mclk);
            rpage_next[ch] = 1'b0;
        end
    endtask

    // answer status_rq after random delays, match packets by address byte
    task automatic collect_packets(input logic [NUM_SENSORS-1:0] want);
        logic [7:0] pkt [4];
        logic       seen [NUM_SENSORS];
        int         delay;
        int         ch;
        for (int i = 0; i < NUM_SENSORS; i++) seen[i] = 1'b0;
        for (int n = 0; n < $countones(want); n++) begin
            delay = int'(next_rand(3));
            while (!(status_rq && delay == 0)) begin
                if (status_rq) delay--;
                @(negedge mclk);
            end
            pkt[0]       = status_ad; // byte 0 with rq
            status_start = 1'b1;
            for (int b = 1; b < STATUS_PKT_BYTES; b++) begin
                @(negedge mclk);
                status_start = 1'b0;
                pkt[b]       = status_ad;
            end
            @(negedge mclk);
            ch = (int'(pkt[0]) - STATUS_REG_BASE) / STATUS_REG_INC;
            check_true(int'(pkt[0]) >= STATUS_REG_BASE && ch < NUM_SENSORS &&
                       int'(pkt[0]) == STATUS_REG_BASE + ch * STATUS_REG_INC && want[ch],
                       $sformatf("status packet with unknown address byte %h", pkt[0]));
            if (ch >= 0 && ch < NUM_SENSORS && want[ch]) begin
                check_true(!seen[ch], $sformatf("channel %0d sent a second packet", ch));
                seen[ch] = 1'b1;
                check_value($sformatf("status byte 1 ch%0d", ch),
                            {bpp_m[ch], en_m[ch], seq_m[ch]}, pkt[1]);
                check_value($sformatf("status line count ch%0d", ch),
                            64'(16'(lcnt_m[ch])), {pkt[3], pkt[2]});
            end
        end
        for (int i = 0; i < NUM_SENSORS; i++) begin
            if (want[i]) check_true(seen[i], $sformatf("no status packet from channel %0d", i));
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge mclk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int err0;
        int len;
        cmd_ad_in    = 8'h00;
        cmd_stb_in   = 1'b0;
        status_start = 1'b0;
        rpage_set    = '0;
        rpage_next   = '0;
        buf_rd       = '0;
        lfsr_state   = SEED;
        for (int c = 0; c < NUM_SENSORS; c++) begin
            pix_in[c]  = '0;
            wpage_m[c] = 0;
            lcnt_m[c]  = 0;
            en_m[c]    = 1'b0;
            bpp_m[c]   = 1'b0;
            seq_m[c]   = '0;
            for (int p = 0; p < 4; p++) exp_len[c][p] = 0;
        end
        wait (rst_n === 1'b1);
        @(negedge mclk);

        err0 = errors;
        check_value("status_rq", 64'd0, 64'(status_rq));
        for (int c = 0; c < NUM_SENSORS; c++) begin
            check_value($sformatf("buf_dout[%0d]", c), 64'd0, buf_dout[c]);
        end
        end_test("reset state", err0);

        err0 = errors;
        for (int c = 0; c < NUM_SENSORS; c++) set_mode(c, 1'b1, 1'b1);
        for (int c = 0; c < NUM_SENSORS; c++) begin
            for (int l = 0; l < LINES_PER_CHAN; l++) feed_line(c, 1 + int'(next_rand(6)));
        end
        for (int c = 0; c < NUM_SENSORS; c++) read_back(c);
        end_test("16-bit packing", err0);

        err0 = errors;
        for (int c = 0; c < NUM_SENSORS; c++) set_mode(c, 1'b1, 1'b0);
        for (int c = 0; c < NUM_SENSORS; c++) begin
            for (int l = 0; l < LINES_PER_CHAN; l++) begin
                len = 1 + int'(next_rand(6));
                if (len % 8 == 0) len--; // always a padded last word
                feed_line(c, len);
            end
        end
        for (int c = 0; c < NUM_SENSORS; c++) read_back(c);
        end_test("8-bit packing", err0);

        err0 = errors;
        set_mode(2, 1'b0, 1'b1);
        feed_line(2, 1 + int'(next_rand(6))); // must be ignored
        set_mode(2, 1'b1, 1'b1);
        feed_line(2, 1 + int'(next_rand(6)));
        read_back(2);
        request_status(2, 6'(next_rand(6)));
        collect_packets(4'b0100);
        end_test("disabled channel", err0);

        err0 = errors;
        for (int c = 0; c < NUM_SENSORS; c++) request_status(c, 6'(next_rand(6)));
        collect_packets(4'b1111);
        end_test("status packets", err0);

        err0 = errors;
        set_mode(0, 1'b1, 1'b1);
        for (int l = 0; l < 6; l++) feed_line(0, 1 + int'(next_rand(6))); // 5 and 6 wrap
        read_back(0);
        end_test("page wraparound", err0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
logic/sensors_pkg.sv
logic/cmd_deser.sv
logic/sensor_ctrl.sv
logic/pixel_packer.sv
logic/sensor_membuf.sv
logic/status_router4.sv
logic/sensors_top.sv
sim/tb_clkgen.sv
sim/sensors_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = sensors_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
